// File: l2_icache.f
+incdir+verilog
verilog/l2_icache_pkg.sv
verilog/l2_icache_lookup.sv
verilog/l2_icache_ctrl.sv
verilog/l2_icache_data.sv
verilog/l2_icache.sv
sim/l2_icache_clk_gen.sv
sim/l2_icache_assert.sv
sim/l2_icache_tb.sv

// File: sim/l2_icache_assert.sv
`timescale 1ns/1ps

module l2_icache_assert (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 cache_read,
    input l2_icache_pkg::addr_t cache_addr,
    input logic                 L2_ready,
    input logic                 mem_read,
    input logic                 mem_ready,
    input l2_icache_pkg::addr_t mem_addr
);

    int fail_count = 0;

    // memory only answers an open request
    ready_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> mem_read)
        else begin
            $error("mem_ready high while mem_read is low");
            fail_count++;
        end

    ready_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        L2_ready |-> cache_read)
        else begin
            $error("L2_ready high while cache_read is low");
            fail_count++;
        end

    ready_or_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        !(L2_ready && mem_read))
        else begin
            $error("L2_ready and mem_read high together");
            fail_count++;
        end

    // full request address goes to memory
    fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_read |-> (mem_addr == cache_addr))
        else begin
            $error("mem_addr differs from cache_addr during mem_read");
            fail_count++;
        end

endmodule

// File: sim/l2_icache_clk_gen.sv
`timescale 1ns/1ps

module l2_icache_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: sim/l2_icache_tb.sv
`timescale 1ns/1ps

`include "l2_icache_settings.svh"

module l2_icache_tb;

    localparam int RESET_CYCLES   = 2;
    localparam int IDLE_CYCLES    = 5;
    localparam int MEM_MAX_DELAY  = 4;
    localparam int N_RANDOM       = 40;
    localparam int N_ACCESSES     = 11 + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_ACCESSES * (MEM_MAX_DELAY + 4) + RESET_CYCLES
                                    + IDLE_CYCLES + 2;

    logic                 clk;
    logic                 rst_n;
    logic                 cache_read;
    l2_icache_pkg::addr_t cache_addr;
    l2_icache_pkg::line_t mem_rdata;
    logic                 mem_ready;
    logic                 L2_ready;
    l2_icache_pkg::line_t cache_rdata;
    logic                 mem_read;
    l2_icache_pkg::addr_t mem_addr;

    integer seed = 52289;
    int     errors = 0;
    int     checked = 0;
    int     cycles = 0;
    string  test_name = "reset";
    logic   mem_busy;
    int     mem_wait;
    logic   saw_mem_read;

    // expected results in request order
    l2_icache_pkg::addr_t exp_addr_q[$];
    logic                 exp_miss_q[$];

    // tag side model with two ways per set
    l2_icache_pkg::tag_t  model_tag [0:1][0:`L2_SETS-1];
    logic                 model_valid [0:1][0:`L2_SETS-1];
    logic                 model_lru [0:`L2_SETS-1];
    l2_icache_pkg::addr_t rand_addr [0:N_RANDOM-1];

    l2_icache_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    l2_icache u_l2_icache (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache_read  (cache_read),
        .cache_addr  (cache_addr),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .L2_ready    (L2_ready),
        .cache_rdata (cache_rdata),
        .mem_read    (mem_read),
        .mem_addr    (mem_addr)
    );

    bind l2_icache l2_icache_assert u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_read (cache_read),
        .cache_addr (cache_addr),
        .L2_ready   (L2_ready),
        .mem_read   (mem_read),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr)
    );

    // every field carries the address, so no two lines are equal
    function automatic l2_icache_pkg::line_t mem_line(input l2_icache_pkg::addr_t addr);
        l2_icache_pkg::addr_t swapped;
        swapped = {addr[13:0], addr[27:14]};
        return {4'h1, addr, 4'h2, ~addr, 4'h3, addr + 28'h1234567, 4'h4, swapped};
    endfunction

    function automatic logic expect_miss(input l2_icache_pkg::addr_t addr);
        l2_icache_pkg::index_t idx;
        l2_icache_pkg::tag_t   tag;
        logic                  victim;
        idx = addr[`L2_INDEX_BITS-1:0];
        tag = addr[`L2_ADDR_BITS-1:`L2_INDEX_BITS];
        if (model_valid[0][idx] && model_tag[0][idx] == tag) begin
            model_lru[idx] = 1'b0;
            return 1'b0;
        end
        if (model_valid[1][idx] && model_tag[1][idx] == tag) begin
            model_lru[idx] = 1'b1;
            return 1'b0;
        end
        // bit set names way 0 as victim
        victim = model_lru[idx] ? 1'b0 : 1'b1;
        model_tag[victim][idx] = tag;
        model_valid[victim][idx] = 1'b1;
        // the hit right after the fill marks the new line as recent
        model_lru[idx] = victim;
        return 1'b1;
    endfunction

    task automatic check_line(input string name, input l2_icache_pkg::line_t expected,
                              input l2_icache_pkg::line_t actual);
        if (actual !== expected) begin
            $display("mismatch %s line: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_miss(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s miss: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic access(input l2_icache_pkg::addr_t addr);
        exp_addr_q.push_back(addr);
        exp_miss_q.push_back(expect_miss(addr));
        cache_read <= 1'b1;
        cache_addr <= addr;
        do begin
            @(posedge clk);
        end while (!L2_ready);
        cache_read <= 1'b0;
        @(posedge clk);
    endtask

    task automatic report_test(input int start_errors, input int accesses);
        if (errors == start_errors) begin
            $display("%s: %0d accesses, ok", test_name, accesses);
        end else begin
            $display("%s: %0d accesses, %0d errors", test_name, accesses,
                     errors - start_errors);
        end
    endtask

    // memory answers 1 to 4 cycles after it sees the request
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_read && !mem_busy) begin
            mem_busy <= 1'b1;
            mem_wait <= {$random(seed)} % MEM_MAX_DELAY;
        end else if (mem_busy) begin
            if (mem_wait == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem_line(mem_addr);
            end else begin
                mem_wait <= mem_wait - 1;
            end
        end
    end

    // compares every delivered line against the reference
    always @(posedge clk) begin
        if (!rst_n) begin
            saw_mem_read = 1'b0;
        end else begin
            if (mem_read) begin
                saw_mem_read = 1'b1;
            end
            if (L2_ready) begin
                if (exp_addr_q.size() == 0) begin
                    $display("%s: L2_ready with no read outstanding", test_name);
                    errors++;
                end else begin
                    check_miss(test_name, exp_miss_q.pop_front(), saw_mem_read);
                    check_line(test_name, mem_line(exp_addr_q.pop_front()), cache_rdata);
                    checked++;
                end
                saw_mem_read = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: request never completed");
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int                   start_errors;
        l2_icache_pkg::tag_t  tag_pool [0:4];
        l2_icache_pkg::addr_t addr_a;
        l2_icache_pkg::addr_t addr_b;
        l2_icache_pkg::addr_t addr_c;
        cache_read = 1'b0;
        cache_addr = '0;
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        mem_busy   = 1'b0;
        mem_wait   = 0;
        for (int s = 0; s < `L2_SETS; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_lru[s] = 1'b0;
        end
        tag_pool = '{24'h000001, 24'h0A0A0A, 24'h123456, 24'hFEDCBA, 24'h800000};
        // five tags over four sets force evictions
        for (int i = 0; i < N_RANDOM; i++) begin
            rand_addr[i] = {tag_pool[{$random(seed)} % 5], 4'(({$random(seed)} % 4) * 5)};
        end
        addr_a = {24'h00A001, 4'h3};
        addr_b = {24'h00B002, 4'h3};
        addr_c = {24'h00C003, 4'h3};

        wait (rst_n);
        @(posedge clk);

        test_name = "idle_after_reset";
        start_errors = errors;
        repeat (IDLE_CYCLES) begin
            @(posedge clk);
            if (L2_ready || mem_read) begin
                $display("%s: L2_ready or mem_read rose with no read pending", test_name);
                errors++;
            end
        end
        report_test(start_errors, 0);

        test_name = "first_read_miss";
        start_errors = errors;
        access(28'h0ABCDE1);
        report_test(start_errors, 1);

        test_name = "repeat_read_hit";
        start_errors = errors;
        access(28'h0ABCDE1);
        report_test(start_errors, 1);

        test_name = "two_tags_one_set";
        start_errors = errors;
        repeat (3) begin
            access(addr_a);
            access(addr_b);
        end
        report_test(start_errors, 6);

        // c replaces a and b stays, then a comes back by a miss
        test_name = "third_tag_evicts";
        start_errors = errors;
        access(addr_c);
        access(addr_b);
        access(addr_a);
        report_test(start_errors, 3);

        test_name = "random_reads";
        start_errors = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            access(rand_addr[i]);
        end
        report_test(start_errors, N_RANDOM);

        if (u_l2_icache.u_assert.fail_count != 0) begin
            $display("%0d protocol assertions failed", u_l2_icache.u_assert.fail_count);
            errors += u_l2_icache.u_assert.fail_count;
        end
        $display("accesses %0d, checked %0d, errors %0d", N_ACCESSES, checked, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/l2_icache.sv
`timescale 1ns/1ps

module l2_icache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cache_read,
    input  l2_icache_pkg::addr_t cache_addr,
    input  l2_icache_pkg::line_t mem_rdata,
    input  logic                 mem_ready,
    output logic                 L2_ready,
    output l2_icache_pkg::line_t cache_rdata,
    output logic                 mem_read,
    output l2_icache_pkg::addr_t mem_addr
);

    logic hit_way0;
    logic hit_way1;
    logic fill;
    logic fill_way;

    l2_icache_lookup u_lookup (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_addr (cache_addr),
        .fill       (fill),
        .fill_way   (fill_way),
        .hit_way0   (hit_way0),
        .hit_way1   (hit_way1)
    );

    l2_icache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_read (cache_read),
        .cache_addr (cache_addr),
        .hit_way0   (hit_way0),
        .hit_way1   (hit_way1),
        .mem_ready  (mem_ready),
        .L2_ready   (L2_ready),
        .mem_read   (mem_read),
        .fill       (fill),
        .fill_way   (fill_way),
        .mem_addr   (mem_addr)
    );

    l2_icache_data u_data (
        .clk         (clk),
        .cache_addr  (cache_addr),
        .hit_way1    (hit_way1),
        .fill        (fill),
        .fill_way    (fill_way),
        .mem_rdata   (mem_rdata),
        .cache_rdata (cache_rdata)
    );

endmodule

// File: verilog/l2_icache_ctrl.sv
`timescale 1ns/1ps

`include "l2_icache_settings.svh"

module l2_icache_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cache_read,
    input  l2_icache_pkg::addr_t cache_addr,
    input  logic                 hit_way0,
    input  logic                 hit_way1,
    input  logic                 mem_ready,
    output logic                 L2_ready,
    output logic                 mem_read,
    output logic                 fill,
    output logic                 fill_way,
    output l2_icache_pkg::addr_t mem_addr
);

    l2_icache_pkg::cache_state_t state;
    l2_icache_pkg::cache_state_t state_next;

    // per set, 1 means way 0 is the victim
    logic [`L2_SETS-1:0] lru;

    l2_icache_pkg::index_t index;
    logic                  hit;
    logic                  lookup;

    assign index  = cache_addr[`L2_INDEX_BITS-1:0];
    assign hit    = hit_way0 | hit_way1;
    assign lookup = (state == l2_icache_pkg::compare_tag) && cache_read;

    always_comb begin
        state_next = state;
        case (state)
            l2_icache_pkg::compare_tag: begin
                if (cache_read && !hit) begin
                    state_next = l2_icache_pkg::allocate;
                end
            end
            l2_icache_pkg::allocate: begin
                if (mem_ready) begin
                    state_next = l2_icache_pkg::compare_tag;
                end
            end
            default: begin
                state_next = l2_icache_pkg::compare_tag;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= l2_icache_pkg::compare_tag;
        end else begin
            state <= state_next;
        end
    end

    assign L2_ready = lookup && hit;

    // request goes out in the miss cycle and stays up until the line arrives
    assign mem_read = (lookup && !hit) || (state == l2_icache_pkg::allocate);
    assign mem_addr = mem_read ? cache_addr : '0;

    assign fill     = (state == l2_icache_pkg::allocate) && mem_ready;
    assign fill_way = ~lru[index];

    // hit in way 1 sets the bit, hit in way 0 clears it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (L2_ready) begin
            lru[index] <= hit_way1;
        end
    end

endmodule

// File: verilog/l2_icache_data.sv
`timescale 1ns/1ps

`include "l2_icache_settings.svh"

module l2_icache_data (
    input  logic                 clk,
    input  l2_icache_pkg::addr_t cache_addr,
    input  logic                 hit_way1,
    input  logic                 fill,
    input  logic                 fill_way,
    input  l2_icache_pkg::line_t mem_rdata,
    output l2_icache_pkg::line_t cache_rdata
);

    // line store, way by set
    l2_icache_pkg::line_t line_mem [0:1][0:`L2_SETS-1];

    l2_icache_pkg::index_t index;
    l2_icache_pkg::line_t  line_way0;
    l2_icache_pkg::line_t  line_way1;

    assign index = cache_addr[`L2_INDEX_BITS-1:0];

    // refill from memory into the victim way
    always_ff @(posedge clk) begin
        if (fill) begin
            line_mem[fill_way][index] <= mem_rdata;
        end
    end

    assign line_way0 = line_mem[0][index];
    assign line_way1 = line_mem[1][index];

    // way 0 is the default, only qualified by L2_ready outside
    always_comb begin
        if (hit_way1) begin
            cache_rdata = line_way1;
        end else begin
            cache_rdata = line_way0;
        end
    end

endmodule

// File: verilog/l2_icache_lookup.sv
`timescale 1ns/1ps

`include "l2_icache_settings.svh"

module l2_icache_lookup (
    input  logic                 clk,
    input  logic                 rst_n,
    input  l2_icache_pkg::addr_t cache_addr,
    input  logic                 fill,
    input  logic                 fill_way,
    output logic                 hit_way0,
    output logic                 hit_way1
);

    // address split
    l2_icache_pkg::index_t index;
    l2_icache_pkg::tag_t   tag;

    // tag store, way by set
    l2_icache_pkg::tag_t tag_mem [0:1][0:`L2_SETS-1];

    // valid bits, one vector per way
    logic [`L2_SETS-1:0] valid [0:1];

    logic [1:0] hit;

    assign index = cache_addr[`L2_INDEX_BITS-1:0];
    assign tag   = cache_addr[`L2_ADDR_BITS-1:`L2_INDEX_BITS];

    // compare both ways of the selected set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid[w][index] && (tag_mem[w][index] == tag);
        end
    end

    assign hit_way0 = hit[0];
    assign hit_way1 = hit[1];

    // tag written with the line on a fill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[fill_way][index] <= tag;
        end
    end

    // valid bits only ever set, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid[0] <= '0;
            valid[1] <= '0;
        end else if (fill) begin
            valid[fill_way][index] <= 1'b1;
        end
    end

endmodule

// File: verilog/l2_icache_pkg.sv
`include "l2_icache_settings.svh"

package l2_icache_pkg;

    typedef logic [`L2_ADDR_BITS-1:0]                  addr_t;
    typedef logic [`L2_ADDR_BITS-`L2_INDEX_BITS-1:0]   tag_t;
    typedef logic [`L2_INDEX_BITS-1:0]                 index_t;
    typedef logic [`L2_LINE_BITS-1:0]                  line_t;

    // miss controller states
    typedef enum logic {
        compare_tag = 1'b0,
        allocate    = 1'b1
    } cache_state_t;

endpackage

// File: verilog/l2_icache_settings.svh
`ifndef L2_ICACHE_SETTINGS_SVH
`define L2_ICACHE_SETTINGS_SVH

// line address width, one address per cache line
`define L2_ADDR_BITS  28

// width of one cache line
`define L2_LINE_BITS  128

// set select bits, low end of the line address
`define L2_INDEX_BITS 4
`define L2_SETS       (1 << `L2_INDEX_BITS)

`endif
